//--- hdl/lru_defs.svh
`ifndef LRU_DEFS_SVH
`define LRU_DEFS_SVH

// ---------------------------------------------------------------------------
// cache geometry
// ---------------------------------------------------------------------------
`define LRU_WAY_BITS 2                        // way number and age width
`define LRU_WAYS (1 << `LRU_WAY_BITS)         // 4 ways
`define LRU_SET_BITS 4                        // set index width
`define LRU_SETS (1 << `LRU_SET_BITS)         // 16 sets

// ---------------------------------------------------------------------------
// register bus
// ---------------------------------------------------------------------------
`define LRU_CFG_ADDR_BITS 2
`define LRU_CFG_DATA_BITS 32

`endif

//--- hdl/lruPkg.sv
`default_nettype none

`include "lru_defs.svh"

package lruPkg;

  // request opcodes from the cache
  typedef enum logic [1:0] {
    LRU_NOP    = 2'd0,
    LRU_TOUCH  = 2'd1,                        // one hit on way A
    LRU_TOUCH2 = 2'd2,                        // hit on A, then on B
    LRU_FILL   = 2'd3                         // miss, victim becomes most recent
  } lruOp_e;

  // register map
  typedef enum logic [`LRU_CFG_ADDR_BITS-1:0] {
    REG_CTRL     = 2'd0,                      // bit 0 enable, bit 1 init start
    REG_STATUS   = 2'd1,                      // bit 0 init busy
    REG_TOUCHCNT = 2'd2,
    REG_FILLCNT  = 2'd3
  } cfgReg_e;

  // ages of all ways in one set, indexed by way number
  typedef logic [`LRU_WAYS-1:0][`LRU_WAY_BITS-1:0] ageVec_t;

endpackage

`default_nettype wire

//--- hdl/lruMemIf.sv
`timescale 1ns/1ps
`default_nettype none

`include "lru_defs.svh"

interface lruMemIf;

  logic [`LRU_SET_BITS-1:0] rdSet;            // combinational read address
  lruPkg::ageVec_t          rdAges;
  logic                     wrEn;             // write at the clock edge
  logic [`LRU_SET_BITS-1:0] wrSet;
  lruPkg::ageVec_t          wrAges;

  // update pipeline side
  modport upd (
    output rdSet,
    input  rdAges,
    output wrEn,
    output wrSet,
    output wrAges
  );

  // age store side
  modport mem (
    input  rdSet,
    output rdAges,
    input  wrEn,
    input  wrSet,
    input  wrAges
  );

endinterface

`default_nettype wire

//--- hdl/lruAgeCell.sv
`timescale 1ns/1ps
`default_nettype none

`include "lru_defs.svh"

module lruAgeCell (
  input  wire  [`LRU_WAY_BITS-1:0] age,       // current age of this way
  input  wire  [`LRU_WAY_BITS-1:0] hitAgeA,   // age of the first touched way
  input  wire  [`LRU_WAY_BITS-1:0] hitAgeB,   // age of the second touched way
  input  wire                      isDouble,
  input  wire                      hold,
  output logic [`LRU_WAY_BITS-1:0] newAge
);

  logic hitThisA;
  logic hitThisB;
  logic youngerA;
  logic youngerB;

  // ---------------------------------------------------------------------------
  // position of this way relative to the touched ways
  // ---------------------------------------------------------------------------
  assign hitThisA = (age == hitAgeA);
  assign hitThisB = isDouble && (age == hitAgeB);
  assign youngerA = (age < hitAgeA);          // more recent than A
  assign youngerB = isDouble && (age < hitAgeB);

  // a way more recent than both touched ways is pushed back by two,
  // one that sits between them by one, older ways stay put
  always_comb begin
    if (hold) begin
      newAge = age;
    end else if (hitThisA) begin
      newAge = '0;                            // A becomes most recent
    end else if (hitThisB) begin
      newAge = `LRU_WAY_BITS'(1);             // B right behind A
    end else if (youngerA && youngerB) begin
      newAge = age + `LRU_WAY_BITS'(2);
    end else if (youngerA || youngerB) begin
      newAge = age + `LRU_WAY_BITS'(1);
    end else begin
      newAge = age;
    end
  end

endmodule

`default_nettype wire

//--- hdl/lruSetUpdate.sv
`timescale 1ns/1ps
`default_nettype none

`include "lru_defs.svh"

module lruSetUpdate (
  input  wire                      clk,
  input  wire                      arstN,
  input  wire                      accValid,
  input  wire lruPkg::lruOp_e      accOp,
  input  wire  [`LRU_SET_BITS-1:0] accSet,
  input  wire  [`LRU_WAY_BITS-1:0] accWayA,
  input  wire  [`LRU_WAY_BITS-1:0] accWayB,
  input  wire                      enable,
  output logic                     respValid,
  output logic [`LRU_WAY_BITS-1:0] respWay,
  output logic                     touchPulse,
  output logic                     fillPulse,
  lruMemIf.upd                     mem
);

  logic                     s1Valid;
  lruPkg::lruOp_e           s1Op;
  logic [`LRU_SET_BITS-1:0] s1Set;
  logic [`LRU_WAY_BITS-1:0] s1WayA;
  logic [`LRU_WAY_BITS-1:0] s1WayB;
  lruPkg::ageVec_t          s1Ages;
  lruPkg::ageVec_t          fwdAges;
  lruPkg::ageVec_t          newAges;
  logic [`LRU_WAY_BITS-1:0] victim;
  logic [`LRU_WAY_BITS-1:0] wayA;
  logic [`LRU_WAY_BITS-1:0] ageA;
  logic [`LRU_WAY_BITS-1:0] ageB;
  logic                     isFill;
  logic                     isTouch;
  logic                     isDouble;

  // ---------------------------------------------------------------------------
  // stage 1: read the set, forward from stage 2 on a set match
  // ---------------------------------------------------------------------------
  assign mem.rdSet = accSet;
  assign fwdAges   = (s1Valid && (s1Set == accSet)) ? newAges : mem.rdAges;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      s1Valid <= 1'b0;
    end else begin
      s1Valid <= accValid && (accOp != lruPkg::LRU_NOP);
    end
  end

  always_ff @(posedge clk) begin
    s1Op   <= accOp;
    s1Set  <= accSet;
    s1WayA <= accWayA;
    s1WayB <= accWayB;
    s1Ages <= fwdAges;
  end

  // ---------------------------------------------------------------------------
  // stage 2: hit ages, victim, per-way update
  // ---------------------------------------------------------------------------
  assign isFill  = (s1Op == lruPkg::LRU_FILL);
  assign isTouch = (s1Op == lruPkg::LRU_TOUCH) || (s1Op == lruPkg::LRU_TOUCH2);

  // victim is the least recent way
  always_comb begin
    victim = '0;
    for (int w = 0; w < `LRU_WAYS; w++) begin
      if (s1Ages[w] == `LRU_WAY_BITS'(`LRU_WAYS - 1)) begin
        victim = `LRU_WAY_BITS'(w);
      end
    end
  end

  assign wayA     = isFill ? victim : s1WayA; // a fill touches the victim
  assign ageA     = s1Ages[wayA];
  assign ageB     = s1Ages[s1WayB];
  assign isDouble = (s1Op == lruPkg::LRU_TOUCH2) && (s1WayA != s1WayB);

  for (genvar w = 0; w < `LRU_WAYS; w++) begin : gCell
    lruAgeCell u_ageCell (
      .age      (s1Ages[w]),
      .hitAgeA  (ageA),
      .hitAgeB  (ageB),
      .isDouble (isDouble),
      .hold     (!enable),
      .newAge   (newAges[w])
    );
  end

  assign mem.wrEn   = s1Valid && enable;
  assign mem.wrSet  = s1Set;
  assign mem.wrAges = newAges;

  // response and event pulses
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      respValid  <= 1'b0;
      touchPulse <= 1'b0;
      fillPulse  <= 1'b0;
    end else begin
      respValid  <= s1Valid;
      touchPulse <= s1Valid && isTouch;
      fillPulse  <= s1Valid && isFill;
    end
  end

  always_ff @(posedge clk) begin
    respWay <= wayA;                          // victim on fill, A otherwise
  end

endmodule

`default_nettype wire

//--- hdl/lruStateMem.sv
`timescale 1ns/1ps
`default_nettype none

`include "lru_defs.svh"

module lruStateMem (
  input  wire  clk,
  input  wire  arstN,
  input  wire  initStart,                     // one-cycle pulse
  output logic initBusy,
  lruMemIf.mem mem
);

  // age equal to way number in every set
  function automatic lruPkg::ageVec_t initPattern();
    lruPkg::ageVec_t pat;
    for (int w = 0; w < `LRU_WAYS; w++) begin
      pat[w] = `LRU_WAY_BITS'(w);
    end
    return pat;
  endfunction

  localparam lruPkg::ageVec_t INIT_AGES = initPattern();
  localparam logic [`LRU_SET_BITS-1:0] LAST_SET = `LRU_SET_BITS'(`LRU_SETS - 1);

  lruPkg::ageVec_t          ages [`LRU_SETS];
  logic [`LRU_SET_BITS-1:0] sweepSet;

  // ---------------------------------------------------------------------------
  // init sweep, one set per cycle
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      initBusy <= 1'b0;
      sweepSet <= '0;
    end else if (initStart) begin
      initBusy <= 1'b1;                       // restart from set 0
      sweepSet <= '0;
    end else if (initBusy) begin
      sweepSet <= sweepSet + `LRU_SET_BITS'(1);
      if (sweepSet == LAST_SET) begin
        initBusy <= 1'b0;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // age array
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int s = 0; s < `LRU_SETS; s++) begin
        ages[s] <= INIT_AGES;
      end
    end else if (initBusy) begin
      ages[sweepSet] <= INIT_AGES;            // pipeline writes dropped here
    end else if (mem.wrEn) begin
      ages[mem.wrSet] <= mem.wrAges;
    end
  end

  assign mem.rdAges = ages[mem.rdSet];

endmodule

`default_nettype wire

//--- hdl/lruCtrlRegs.sv
`timescale 1ns/1ps
`default_nettype none

`include "lru_defs.svh"

module lruCtrlRegs (
  input  wire                           clk,
  input  wire                           arstN,
  input  wire                           cfgWrite,
  input  wire                           cfgRead,
  input  wire  [`LRU_CFG_ADDR_BITS-1:0] cfgAddr,
  input  wire  [`LRU_CFG_DATA_BITS-1:0] cfgWData,
  input  wire                           initBusy,
  input  wire                           touchPulse,
  input  wire                           fillPulse,
  output logic [`LRU_CFG_DATA_BITS-1:0] cfgRData,
  output logic                          enable,
  output logic                          initStart
);

  lruPkg::cfgReg_e               regAddr;
  logic [`LRU_CFG_DATA_BITS-1:0] touchCnt;
  logic [`LRU_CFG_DATA_BITS-1:0] fillCnt;
  logic [`LRU_CFG_DATA_BITS-1:0] rdMux;

  assign regAddr = lruPkg::cfgReg_e'(cfgAddr);

  // ---------------------------------------------------------------------------
  // control register and init pulse
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      enable    <= 1'b1;
      initStart <= 1'b0;
    end else begin
      initStart <= 1'b0;                      // single cycle
      if (cfgWrite && (regAddr == lruPkg::REG_CTRL)) begin
        enable    <= cfgWData[0];
        initStart <= cfgWData[1];
      end
    end
  end

  // event counters, wrap on overflow
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      touchCnt <= '0;
      fillCnt  <= '0;
    end else begin
      if (touchPulse) begin
        touchCnt <= touchCnt + `LRU_CFG_DATA_BITS'(1);
      end
      if (fillPulse) begin
        fillCnt <= fillCnt + `LRU_CFG_DATA_BITS'(1);
      end
    end
  end

  // ---------------------------------------------------------------------------
  // read path
  // ---------------------------------------------------------------------------
  always_comb begin
    rdMux = '0;
    case (regAddr)
      lruPkg::REG_CTRL:     rdMux[0] = enable;
      lruPkg::REG_STATUS:   rdMux[0] = initBusy;
      lruPkg::REG_TOUCHCNT: rdMux    = touchCnt;
      lruPkg::REG_FILLCNT:  rdMux    = fillCnt;
      default:              rdMux    = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      cfgRData <= '0;
    end else if (cfgRead) begin
      cfgRData <= rdMux;                      // valid the cycle after cfgRead
    end
  end

endmodule

`default_nettype wire

//--- hdl/lruTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "lru_defs.svh"

module lruTop (
  input  wire                           clk,
  input  wire                           arstN,
  // request from the cache
  input  wire                           accValid,
  input  wire lruPkg::lruOp_e           accOp,
  input  wire  [`LRU_SET_BITS-1:0]      accSet,
  input  wire  [`LRU_WAY_BITS-1:0]      accWayA,
  input  wire  [`LRU_WAY_BITS-1:0]      accWayB,
  // response two cycles later
  output logic                          respValid,
  output logic [`LRU_WAY_BITS-1:0]      respWay,
  // register bus
  input  wire                           cfgWrite,
  input  wire                           cfgRead,
  input  wire  [`LRU_CFG_ADDR_BITS-1:0] cfgAddr,
  input  wire  [`LRU_CFG_DATA_BITS-1:0] cfgWData,
  output logic [`LRU_CFG_DATA_BITS-1:0] cfgRData,
  output logic                          initBusy
);

  logic enable;
  logic initStart;
  logic touchPulse;
  logic fillPulse;

  lruMemIf memIf ();

  lruSetUpdate u_setUpdate (
    .clk        (clk),
    .arstN      (arstN),
    .accValid   (accValid),
    .accOp      (accOp),
    .accSet     (accSet),
    .accWayA    (accWayA),
    .accWayB    (accWayB),
    .enable     (enable),
    .respValid  (respValid),
    .respWay    (respWay),
    .touchPulse (touchPulse),
    .fillPulse  (fillPulse),
    .mem        (memIf.upd)
  );

  lruStateMem u_stateMem (
    .clk       (clk),
    .arstN     (arstN),
    .initStart (initStart),
    .initBusy  (initBusy),
    .mem       (memIf.mem)
  );

  lruCtrlRegs u_ctrlRegs (
    .clk        (clk),
    .arstN      (arstN),
    .cfgWrite   (cfgWrite),
    .cfgRead    (cfgRead),
    .cfgAddr    (cfgAddr),
    .cfgWData   (cfgWData),
    .initBusy   (initBusy),
    .touchPulse (touchPulse),
    .fillPulse  (fillPulse),
    .cfgRData   (cfgRData),
    .enable     (enable),
    .initStart  (initStart)
  );

endmodule

`default_nettype wire

//--- bench/lruTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lru_defs.svh"

module lruTb;

  localparam int WB             = `LRU_WAY_BITS;
  localparam int TIMEOUT_CYCLES = 4000;       // tests need about 1500 cycles

  // ways listed from most recent to least recent
  typedef logic [`LRU_WAYS-1:0][`LRU_WAY_BITS-1:0] wayList_t;

  logic                          clk;
  logic                          arstN;
  logic                          accValid;
  lruPkg::lruOp_e                accOp;
  logic [`LRU_SET_BITS-1:0]      accSet;
  logic [`LRU_WAY_BITS-1:0]      accWayA;
  logic [`LRU_WAY_BITS-1:0]      accWayB;
  logic                          respValid;
  logic [`LRU_WAY_BITS-1:0]      respWay;
  logic                          cfgWrite;
  logic                          cfgRead;
  logic [`LRU_CFG_ADDR_BITS-1:0] cfgAddr;
  logic [`LRU_CFG_DATA_BITS-1:0] cfgWData;
  logic [`LRU_CFG_DATA_BITS-1:0] cfgRData;
  logic                          initBusy;

  lruPkg::ageVec_t               refAges [`LRU_SETS];
  logic                          refEnable;    // model copy of the enable bit
  logic [`LRU_WAY_BITS-1:0]      expQ [$];     // expected response ways
  int                            dueQ [$];     // cycle in which each response is due
  int                            touchSent;
  int                            fillSent;
  int                            cycleCount;

  lruTop u_lruTop (
    .clk       (clk),
    .arstN     (arstN),
    .accValid  (accValid),
    .accOp     (accOp),
    .accSet    (accSet),
    .accWayA   (accWayA),
    .accWayB   (accWayB),
    .respValid (respValid),
    .respWay   (respWay),
    .cfgWrite  (cfgWrite),
    .cfgRead   (cfgRead),
    .cfgAddr   (cfgAddr),
    .cfgWData  (cfgWData),
    .cfgRData  (cfgRData),
    .initBusy  (initBusy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic failRun(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped");
  endtask

  // ---------------------------------------------------------------------------
  // reference model, true LRU kept as a recency list
  // ---------------------------------------------------------------------------
  function automatic wayList_t promote(input wayList_t order, input logic [WB-1:0] way);
    wayList_t res;
    int       k;
    res    = order;
    res[0] = way;
    k      = 1;
    for (int p = 0; p < `LRU_WAYS; p++) begin
      if ((order[WB'(p)] != way) && (k < `LRU_WAYS)) begin
        res[WB'(k)] = order[WB'(p)];
        k++;
      end
    end
    return res;
  endfunction

  // new ages of one set, returns the way the response must carry
  function automatic logic [WB-1:0] refUpdate(
    input  lruPkg::ageVec_t cur,
    input  lruPkg::lruOp_e  op,
    input  logic [WB-1:0]   wayA,
    input  logic [WB-1:0]   wayB,
    input  logic            en,
    output lruPkg::ageVec_t nxt
  );
    wayList_t      order;
    logic [WB-1:0] first;
    order = '0;
    for (int w = 0; w < `LRU_WAYS; w++) begin
      order[cur[WB'(w)]] = WB'(w);
    end
    first = (op == lruPkg::LRU_FILL) ? order[WB'(`LRU_WAYS - 1)] : wayA;
    if (op == lruPkg::LRU_TOUCH2) begin
      order = promote(order, wayB);           // B goes first so A ends in front
    end
    order = promote(order, first);
    nxt = cur;
    if (en) begin
      for (int p = 0; p < `LRU_WAYS; p++) begin
        nxt[order[WB'(p)]] = WB'(p);
      end
    end
    return first;
  endfunction

  task automatic resetModel();
    for (int s = 0; s < `LRU_SETS; s++) begin
      for (int w = 0; w < `LRU_WAYS; w++) begin
        refAges[s][WB'(w)] = WB'(w);          // age equals way number
      end
    end
  endtask

  // ---------------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------------
  task automatic sendReq(input lruPkg::lruOp_e op, input logic [`LRU_SET_BITS-1:0] set,
                         input logic [WB-1:0] wayA, input logic [WB-1:0] wayB);
    lruPkg::ageVec_t nxt;
    logic [WB-1:0]   expWay;
    expWay = refUpdate(refAges[set], op, wayA, wayB, refEnable, nxt);
    refAges[set] = nxt;
    expQ.push_back(expWay);
    dueQ.push_back(cycleCount + 2);           // response two edges after the drive
    if (op == lruPkg::LRU_FILL) begin
      fillSent++;
    end else begin
      touchSent++;
    end
    accValid = 1'b1;
    accOp    = op;
    accSet   = set;
    accWayA  = wayA;
    accWayB  = wayB;
    @(posedge clk);
    #1;
    accValid = 1'b0;
  endtask

  task automatic randomReq(input logic [`LRU_SET_BITS-1:0] set, input logic touchOnly);
    lruPkg::lruOp_e op;
    if (touchOnly) begin
      op = lruPkg::lruOp_e'(2'($urandom_range(1, 2)));
    end else begin
      op = lruPkg::lruOp_e'(2'($urandom_range(1, 3)));
    end
    sendReq(op, set, WB'($urandom_range(0, `LRU_WAYS - 1)),
            WB'($urandom_range(0, `LRU_WAYS - 1)));
  endtask

  // wait until every outstanding response has been compared
  task automatic drain();
    while (expQ.size() > 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic writeReg(input lruPkg::cfgReg_e addr, input logic [31:0] data);
    cfgWrite = 1'b1;
    cfgAddr  = addr;
    cfgWData = data;
    @(posedge clk);
    #1;
    cfgWrite = 1'b0;
  endtask

  task automatic readReg(input lruPkg::cfgReg_e addr, output logic [31:0] data);
    cfgRead = 1'b1;
    cfgAddr = addr;
    @(posedge clk);
    #1;
    cfgRead = 1'b0;
    data    = cfgRData;                       // registered one cycle after cfgRead
  endtask

  task automatic checkReg(input lruPkg::cfgReg_e addr, input logic [31:0] exp,
                          input string what);
    logic [31:0] rd;
    readReg(addr, rd);
    assert (rd == exp)
      else failRun($sformatf("Fail %0t: %s read 0x%0h, expected 0x%0h",
                             $time, what, rd, exp));
  endtask

  // ---------------------------------------------------------------------------
  // response compare and timeout
  // ---------------------------------------------------------------------------
  always @(negedge clk) begin
    logic [WB-1:0] expWay;
    int            due;
    if (arstN && respValid) begin
      assert (expQ.size() > 0)
        else failRun("response arrived with no request outstanding");
      if (expQ.size() > 0) begin
        expWay = expQ.pop_front();
        due    = dueQ.pop_front();
        assert (cycleCount == due)
          else failRun($sformatf("Fail %0t: response in cycle %0d, expected in cycle %0d",
                                 $time, cycleCount, due));
        assert (respWay == expWay)
          else failRun($sformatf("Fail %0t: respWay %0d, expected %0d",
                                 $time, respWay, expWay));
      end
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      failRun($sformatf("timeout: the run did not finish within %0d cycles",
                        TIMEOUT_CYCLES));
    end
  end

  // ---------------------------------------------------------------------------
  // test sequence
  // ---------------------------------------------------------------------------
  initial begin
    logic [31:0] rd;
    int          busyReads;
    void'($urandom(32'h6143_9561));
    cycleCount = 0;
    touchSent  = 0;
    fillSent   = 0;
    refEnable  = 1'b1;
    arstN      = 1'b0;
    accValid   = 1'b0;
    accOp      = lruPkg::LRU_NOP;
    accSet     = '0;
    accWayA    = '0;
    accWayB    = '0;
    cfgWrite   = 1'b0;
    cfgRead    = 1'b0;
    cfgAddr    = '0;
    cfgWData   = '0;
    resetModel();
    repeat (3) @(posedge clk);
    #1;
    arstN = 1'b1;

    // fills from the reset order, victims 3 2 1 0 3
    for (int s = 0; s < `LRU_SETS; s++) begin
      for (int n = 0; n < 5; n++) begin
        sendReq(lruPkg::LRU_FILL, `LRU_SET_BITS'(s), '0, '0);
        drain();
      end
    end

    // random serial traffic, one double touch with equal ways for sure
    sendReq(lruPkg::LRU_TOUCH2, `LRU_SET_BITS'(3), 2'd2, 2'd2);
    drain();
    for (int n = 0; n < 150; n++) begin
      randomReq(`LRU_SET_BITS'($urandom_range(0, `LRU_SETS - 1)), 1'b0);
      drain();
    end
    for (int s = 0; s < `LRU_SETS; s++) begin
      sendReq(lruPkg::LRU_FILL, `LRU_SET_BITS'(s), '0, '0);
      drain();
    end

    // back to back on two sets to exercise forwarding
    for (int n = 0; n < 80; n++) begin
      randomReq(`LRU_SET_BITS'($urandom_range(0, 1)), 1'b0);
    end
    drain();

    // touches with the update disabled
    checkReg(lruPkg::REG_CTRL, 32'h1, "REG_CTRL after reset");
    writeReg(lruPkg::REG_CTRL, 32'h0);
    refEnable = 1'b0;
    checkReg(lruPkg::REG_CTRL, 32'h0, "REG_CTRL disabled");
    for (int n = 0; n < 20; n++) begin
      randomReq(`LRU_SET_BITS'(5), 1'b1);
    end
    drain();
    writeReg(lruPkg::REG_CTRL, 32'h1);
    refEnable = 1'b1;
    sendReq(lruPkg::LRU_FILL, `LRU_SET_BITS'(5), '0, '0);
    drain();
    checkReg(lruPkg::REG_TOUCHCNT, 32'(touchSent), "REG_TOUCHCNT");
    checkReg(lruPkg::REG_FILLCNT, 32'(fillSent), "REG_FILLCNT");

    // init sweep, busy for one read per set
    writeReg(lruPkg::REG_CTRL, 32'h3);
    @(posedge clk);
    #1;
    assert (initBusy)
      else failRun($sformatf("Fail %0t: initBusy low after the init write", $time));
    busyReads = 0;
    readReg(lruPkg::REG_STATUS, rd);
    while (rd[0]) begin
      busyReads++;
      readReg(lruPkg::REG_STATUS, rd);
    end
    assert (busyReads == `LRU_SETS)
      else failRun($sformatf("Fail %0t: initBusy seen for %0d reads, expected %0d",
                             $time, busyReads, `LRU_SETS));
    assert (!initBusy)
      else failRun($sformatf("Fail %0t: initBusy still high after the sweep", $time));
    checkReg(lruPkg::REG_CTRL, 32'h1, "REG_CTRL after init");
    resetModel();
    for (int s = 0; s < `LRU_SETS; s++) begin
      sendReq(lruPkg::LRU_FILL, `LRU_SET_BITS'(s), '0, '0);
      drain();
    end

    checkReg(lruPkg::REG_TOUCHCNT, 32'(touchSent), "REG_TOUCHCNT");
    checkReg(lruPkg::REG_FILLCNT, 32'(fillSent), "REG_FILLCNT");
    drain();
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hdl
hdl/lruPkg.sv
hdl/lruMemIf.sv
hdl/lruAgeCell.sv
hdl/lruSetUpdate.sv
hdl/lruStateMem.sv
hdl/lruCtrlRegs.sv
hdl/lruTop.sv
bench/lruTb.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f vlog.f --top-module lruTb -o lruTb

run: compile
	@out="$$(./obj_dir/lruTb 2>&1)"; echo "$$out"; echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir
